// ==== hw/sha_miner_pkg.sv ====
// SHA miner shared definitions
package sha_miner_pkg;

	typedef logic [31:0] word_t;          // One SHA word
	typedef logic [31:0] nonce_t;
	typedef logic [0:7][31:0] digest_t;   // Word 0 is H0
	typedef logic [0:15][31:0] block_t;   // Word 0 is W0
	typedef logic [7:0] step_t;           // Run schedule position

	typedef enum logic {
		MODE_INIT,    // Start from standard H0..H7
		MODE_CHAIN    // Start from previous block result
	} hash_mode_t;

	typedef enum logic [2:0] {
		DB_IDLE,
		DB_WAIT_PRESS,
		DB_PULSE,
		DB_WAIT_LONG,
		DB_LONG,
		DB_WAIT_OFF,
		DB_WAIT_LOFF
	} debounce_state_t;

	//////////////////////////////
	// SHA-256 constants
	localparam logic [0:63][31:0] ROUND_K = {
		256'h428a2f98_71374491_b5c0fbcf_e9b5dba5_3956c25b_59f111f1_923f82a4_ab1c5ed5,
		256'hd807aa98_12835b01_243185be_550c7dc3_72be5d74_80deb1fe_9bdc06a7_c19bf174,
		256'he49b69c1_efbe4786_0fc19dc6_240ca1cc_2de92c6f_4a7484aa_5cb0a9dc_76f988da,
		256'h983e5152_a831c66d_b00327c8_bf597fc7_c6e00bf3_d5a79147_06ca6351_14292967,
		256'h27b70a85_2e1b2138_4d2c6dfc_53380d13_650a7354_766a0abb_81c2c92e_92722c85,
		256'ha2bfe8a1_a81a664b_c24b8b70_c76c51a3_d192e819_d6990624_f40e3585_106aa070,
		256'h19a4c116_1e376c08_2748774c_34b0bcb5_391c0cb3_4ed8aa4a_5b9cca4f_682e6ff3,
		256'h748f82ee_78a5636f_84c87814_8cc70208_90befffa_a4506ceb_bef9a3f7_c67178f2
	};
	localparam digest_t HASH_INIT = {
		128'h6a09e667_bb67ae85_3c6ef372_a54ff53a,
		128'h510e527f_9b05688c_1f83d9ab_5be0cd19
	};

	//////////////////////////////
	// Block header and padding
	// Each 4-byte group is a little endian field, reversed into its SHA word
	localparam logic [0:79][7:0] HEADER = {
		128'h00000001_4cc2c57c_7905fd39_9965282c,
		128'h87fe259e_7da366e0_35dc087a_0000141f,
		128'h00000000_6427b649_2f2b0525_78fb4bc2,
		128'h3655ca4e_8b9e2b9b_69c88041_b2ac8c77,
		128'h1571d1be_4de69593_1a269421_7a33330e  // Last field is the nonce
	};
	localparam int NONCE_WORD = 3;                                // Nonce slot in block 1
	localparam logic [0:11][31:0] BLOCK1_PAD = {32'h8000_0000, 320'h0, 32'h0000_0280};
	localparam digest_t DIGEST_PAD = {32'h8000_0000, 192'h0, 32'h0000_0100};
	localparam nonce_t NONCE_START = 32'h7a33_330e;

	// Fixed per-nonce schedule
	localparam step_t ROUND_LATENCY = 8'd65;                    // in_valid to out_valid
	localparam step_t STEP_BLOCK0   = 8'd2;
	localparam step_t STEP_BLOCK1   = STEP_BLOCK0 + ROUND_LATENCY;   // 67
	localparam step_t STEP_LAST     = STEP_BLOCK1 + ROUND_LATENCY;   // 132

	typedef struct packed {
		digest_t digest;   // Second hash output
		nonce_t  nonce;    // Tag of the hashed nonce
		logic    hit;      // Enough leading zero bits
	} digest_result_t;

endpackage

// ==== hw/button_debounce.sv ====
// Push button debounce
`timescale 1ns/1ps
module button_debounce import sha_miner_pkg::*; #(
	parameter int unsigned PRESS_CYCLES   = 240_000,
	parameter int unsigned PULSE_CYCLES   = 960_000,
	parameter int unsigned LONG_CYCLES    = 32_000_000,
	parameter int unsigned RELEASE_CYCLES = 4_800_000
) (
	input  logic clk,
	input  logic reset,
	input  logic button,
	output logic short_fire,
	output logic long_fire
);

	logic [2:0]      sync;            // Metastability chain
	logic            btn;
	debounce_state_t state;
	debounce_state_t state_next;
	logic [31:0]     press_count;     // Cycles since press started
	logic [31:0]     release_count;   // Cycles released while waiting off

	assign btn = sync[2];

	always_ff @(posedge clk) begin
		if (reset) begin
			sync <= '0;
		end else begin
			sync <= {sync[1:0], button};
		end
	end

	// Press classification
	always_comb begin
		state_next = state;
		case (state)
			DB_IDLE:       if (btn) state_next = DB_WAIT_PRESS;
			DB_WAIT_PRESS: if (!btn) state_next = DB_IDLE;
				else if (press_count == PRESS_CYCLES) state_next = DB_PULSE;
			DB_PULSE:      if (press_count == PRESS_CYCLES + PULSE_CYCLES) state_next = DB_WAIT_LONG;
			DB_WAIT_LONG:  if (!btn) state_next = DB_WAIT_OFF;
				else if (press_count >= LONG_CYCLES) state_next = DB_LONG;
			DB_LONG:       if (!btn) state_next = DB_WAIT_LOFF;
			DB_WAIT_OFF:   if (btn) state_next = DB_WAIT_LONG;   // Bounce back, still may go long
				else if (release_count == RELEASE_CYCLES) state_next = DB_IDLE;
			DB_WAIT_LOFF:  if (btn) state_next = DB_LONG;
				else if (release_count == RELEASE_CYCLES) state_next = DB_IDLE;
			default:       state_next = DB_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state         <= DB_IDLE;
			short_fire    <= 1'b0;
			press_count   <= '0;
			release_count <= '0;
		end else begin
			state      <= state_next;
			short_fire <= (state_next == DB_PULSE) && (state != DB_PULSE);   // Entry strobe
			if (state == DB_IDLE) begin
				press_count <= '0;
			end else if (press_count != '1) begin
				press_count <= press_count + 32'd1;   // Saturates on very long holds
			end
			if (state == DB_WAIT_OFF || state == DB_WAIT_LOFF) begin
				release_count <= release_count + 32'd1;
			end else begin
				release_count <= '0;
			end
		end
	end

	assign long_fire = (state == DB_LONG) || (state == DB_WAIT_LOFF);   // Held past long time

endmodule

// ==== hw/scan_control.sv ====
// Nonce scan run control
`timescale 1ns/1ps
module scan_control import sha_miner_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        short_fire,
	input  logic        long_fire,
	input  logic        hit,
	output logic        get_msg,
	output logic        load_block,
	output logic        block_sel,
	output hash_mode_t  mode,
	output logic        running,
	output logic [47:0] op_count
);

	step_t step;          // 0 is idle, 1..STEP_LAST per nonce
	step_t drain;         // Second hash still busy
	logic  continuous;
	logic  start_req;     // Short press waiting for a slot
	logic  long_fire_q;
	logic  sha_go;
	logic  start;

	assign sha_go = start_req | continuous;
	assign start  = sha_go && (step == '0 || step == STEP_LAST);   // Back to back at the last step

	//////////////////////////////
	// Run mode
	always_ff @(posedge clk) begin
		if (reset) begin
			long_fire_q <= 1'b0;
			continuous  <= 1'b0;
			start_req   <= 1'b0;
		end else begin
			long_fire_q <= long_fire;
			if (long_fire && !long_fire_q) begin
				continuous <= 1'b1;          // Rising edge of a long hold
			end else if (hit || short_fire) begin
				continuous <= 1'b0;
			end
			if (short_fire) begin
				start_req <= 1'b1;
			end else if (start) begin
				start_req <= 1'b0;           // Taken by the step counter
			end
		end
	end

	//////////////////////////////
	// Step counter
	always_ff @(posedge clk) begin
		if (reset) begin
			step  <= '0;
			drain <= '0;
		end else begin
			if (start) begin
				step <= 8'd1;
			end else if (step == STEP_LAST) begin
				step <= '0;
			end else if (step != '0) begin
				step <= step + 8'd1;
			end
			if (step == STEP_LAST) begin
				drain <= ROUND_LATENCY;       // Covers the second hash of this nonce
			end else if (drain != '0) begin
				drain <= drain - 8'd1;
			end
		end
	end

	// Schedule strobes
	assign get_msg    = (step == 8'd1);
	assign block_sel  = (step == STEP_BLOCK1);
	assign load_block = (step == STEP_BLOCK0) || block_sel;
	assign mode       = block_sel ? MODE_CHAIN : MODE_INIT;
	assign running    = continuous | start_req | (step != '0) | (drain != '0);

	// One count per started nonce
	always_ff @(posedge clk) begin
		if (reset) begin
			op_count <= '0;
		end else if (step == STEP_BLOCK1) begin
			op_count <= op_count + 48'd1;
		end
	end

endmodule

// ==== hw/nonce_tracker.sv ====
// Nonce counter and tag pipeline
`timescale 1ns/1ps
module nonce_tracker import sha_miner_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   get_msg,
	input  logic   first_done,
	input  logic   second_done,
	input  logic   hit,
	output nonce_t nonce,
	output nonce_t result_nonce,
	output nonce_t found_nonce,
	output logic   found_valid
);

	logic   issue_q;      // Block 0 starts the cycle after get_msg
	nonce_t issue_tag;    // Latched with the message blocks
	nonce_t first_tag;    // In the first engine
	nonce_t second_tag;   // In the second engine

	always_ff @(posedge clk) begin
		if (reset) begin
			nonce       <= NONCE_START;
			issue_q     <= 1'b0;
			found_valid <= 1'b0;
		end else begin
			issue_q <= get_msg;
			if (get_msg) begin
				nonce[19:0] <= nonce[19:0] + 20'd1;   // Upper 12 bits fixed
			end
			if (second_done && hit) begin
				found_valid <= 1'b1;
			end
		end
	end

	// Tags follow the hash stages
	always_ff @(posedge clk) begin
		if (get_msg) issue_tag <= nonce;
		if (issue_q) first_tag <= issue_tag;
		if (first_done) second_tag <= first_tag;
		if (second_done && hit) found_nonce <= second_tag;
	end

	assign result_nonce = second_tag;

endmodule

// ==== hw/sha256_block.sv ====
// SHA-256 block compression engine
`timescale 1ns/1ps
module sha256_block import sha_miner_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       in_valid,
	input  hash_mode_t mode,
	input  block_t     message,
	output logic       out_valid,
	output digest_t    hash
);

	function automatic word_t rotr(input word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	logic       busy;
	logic [5:0] round;
	logic       last_round;
	digest_t    work;          // a..h
	digest_t    work_next;
	digest_t    chain;         // Start value, then the block result
	digest_t    chain_next;
	digest_t    start_value;
	block_t     sched;         // sched[0] is W for the current round
	word_t      big_s0;
	word_t      big_s1;
	word_t      ch;
	word_t      maj;
	word_t      t1;
	word_t      t2;
	word_t      w_new;         // W sixteen rounds ahead

	assign last_round  = (round == 6'd63);
	assign start_value = (mode == MODE_CHAIN) ? chain : HASH_INIT;
	assign hash        = chain;

	//////////////////////////////
	// One round
	always_comb begin
		big_s1 = rotr(work[4], 6) ^ rotr(work[4], 11) ^ rotr(work[4], 25);
		ch     = (work[4] & work[5]) ^ (~work[4] & work[6]);
		t1     = work[7] + big_s1 + ch + ROUND_K[round] + sched[0];
		big_s0 = rotr(work[0], 2) ^ rotr(work[0], 13) ^ rotr(work[0], 22);
		maj    = (work[0] & work[1]) ^ (work[0] & work[2]) ^ (work[1] & work[2]);
		t2     = big_s0 + maj;
		work_next = {t1 + t2, work[0:2], work[3] + t1, work[4:6]};
		// Schedule expansion, small sigmas inline
		w_new = (rotr(sched[14], 17) ^ rotr(sched[14], 19) ^ (sched[14] >> 10))
			+ sched[9]
			+ (rotr(sched[1], 7) ^ rotr(sched[1], 18) ^ (sched[1] >> 3))
			+ sched[0];
		for (int i = 0; i < 8; i++) begin
			chain_next[i] = chain[i] + work_next[i];   // Final add after round 63
		end
	end

	//////////////////////////////
	// Round sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			busy      <= 1'b0;
			round     <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= busy & last_round;
			if (in_valid) begin
				busy  <= 1'b1;
				round <= '0;
			end else if (busy) begin
				round <= round + 6'd1;
				if (last_round) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// Working state and message window
	always_ff @(posedge clk) begin
		if (in_valid) begin
			work  <= start_value;
			chain <= start_value;
			sched <= message;
		end else if (busy) begin
			work  <= work_next;
			sched <= {sched[1:15], w_new};   // Slide one word
			if (last_round) begin
				chain <= chain_next;
			end
		end
	end

endmodule

// ==== hw/sha_miner.sv ====
// Double SHA-256 nonce scanner
`timescale 1ns/1ps
module sha_miner import sha_miner_pkg::*; #(
	parameter int unsigned PRESS_CYCLES   = 240_000,      // 5 ms at 48 MHz
	parameter int unsigned PULSE_CYCLES   = 960_000,
	parameter int unsigned LONG_CYCLES    = 32_000_000,   // About 2/3 s
	parameter int unsigned RELEASE_CYCLES = 4_800_000,
	parameter int unsigned HIT_ZERO_BITS  = 32
) (
	input  logic           clk,
	input  logic           reset,
	input  logic           fire_button,
	output logic           result_valid,
	output digest_result_t result,
	output logic           running,
	output logic           found_valid,
	output nonce_t         found_nonce,
	output logic [47:0]    op_count
);

	logic              short_fire;
	logic              long_fire;
	logic              get_msg;
	logic              load_block;
	logic              block_sel;
	hash_mode_t        mode;
	logic              hit;
	nonce_t            nonce;
	nonce_t            result_nonce;
	logic [0:19][31:0] hdr_words;     // Header as SHA words
	block_t            block0_next;
	block_t            block1_next;
	block_t            block0_q;
	block_t            block1_q;
	logic              last_sel;      // Block in the first engine
	logic              first_valid;
	logic              first_done;
	digest_t           first_hash;
	logic              second_valid;
	digest_t           second_hash;
	logic              hash_zero;

	button_debounce #(
		.PRESS_CYCLES  (PRESS_CYCLES),
		.PULSE_CYCLES  (PULSE_CYCLES),
		.LONG_CYCLES   (LONG_CYCLES),
		.RELEASE_CYCLES(RELEASE_CYCLES)
	) i_debounce (
		.clk       (clk),
		.reset     (reset),
		.button    (fire_button),
		.short_fire(short_fire),
		.long_fire (long_fire)
	);

	scan_control i_control (
		.clk       (clk),
		.reset     (reset),
		.short_fire(short_fire),
		.long_fire (long_fire),
		.hit       (hit),
		.get_msg   (get_msg),
		.load_block(load_block),
		.block_sel (block_sel),
		.mode      (mode),
		.running   (running),
		.op_count  (op_count)
	);

	nonce_tracker i_nonce (
		.clk         (clk),
		.reset       (reset),
		.get_msg     (get_msg),
		.first_done  (first_done),
		.second_done (second_valid),
		.hit         (hit),
		.nonce       (nonce),
		.result_nonce(result_nonce),
		.found_nonce (found_nonce),
		.found_valid (found_valid)
	);

	//////////////////////////////
	// Message blocks
	always_comb begin
		for (int w = 0; w < 20; w++) begin
			hdr_words[w] = {HEADER[4*w+3], HEADER[4*w+2], HEADER[4*w+1], HEADER[4*w]};
		end
		block0_next = hdr_words[0:15];
		block1_next = {hdr_words[16:19], BLOCK1_PAD};
		block1_next[NONCE_WORD] = {nonce[7:0], nonce[15:8], nonce[23:16], nonce[31:24]};
	end

	always_ff @(posedge clk) begin
		if (get_msg) begin
			block0_q <= block0_next;
			block1_q <= block1_next;
		end
	end

	// Only the block 1 result goes on to the second hash
	always_ff @(posedge clk) begin
		if (reset) begin
			last_sel <= 1'b0;
		end else if (load_block) begin
			last_sel <= block_sel;
		end
	end
	assign first_done = first_valid & last_sel;

	//////////////////////////////
	// Hash stages
	sha256_block i_sha_first (
		.clk      (clk),
		.reset    (reset),
		.in_valid (load_block),
		.mode     (mode),
		.message  (block_sel ? block1_q : block0_q),
		.out_valid(first_valid),
		.hash     (first_hash)
	);

	sha256_block i_sha_second (
		.clk      (clk),
		.reset    (reset),
		.in_valid (first_done),
		.mode     (MODE_INIT),
		.message  ({first_hash, DIGEST_PAD}),
		.out_valid(second_valid),
		.hash     (second_hash)
	);

	// Hit on top bits of the last word
	assign hash_zero = (second_hash[7][31 -: HIT_ZERO_BITS] == '0);
	assign hit       = second_valid & hash_zero;

	assign result_valid  = second_valid;
	assign result.digest = second_hash;
	assign result.nonce  = result_nonce;
	assign result.hit    = hash_zero;

endmodule

// ==== testbench/sha_miner_checker.sv ====
// SHA miner result checker
`timescale 1ns/1ps
module sha_miner_checker import sha_miner_pkg::*; #(
	parameter int unsigned HIT_ZERO_BITS = 32
) (
	input  logic           clk,
	input  logic           reset,
	input  logic           result_valid,
	input  digest_result_t result,
	input  logic           running,
	input  logic           found_valid,
	input  nonce_t         found_nonce,
	input  logic [47:0]    op_count,
	input  logic           test_open,
	input  logic           test_long,
	input  int             test_num,
	output int             error_count,
	output int             result_count
);

	nonce_t expected_nonce;   // Next nonce in scan order
	nonce_t last_hit_nonce;
	logic   any_hit;
	logic   open_q;
	string  label;
	int     test_results;
	int     test_hits;
	int     after_hit;        // Results behind the first hit of a test
	int     errors_at_start;

	//////////////////////////////
	// Reference SHA-256
	function automatic word_t ror(input word_t x, input int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic digest_t compress(input digest_t h_in, input block_t blk);
		word_t   w [0:63];
		word_t   v [0:7];    // a..h
		word_t   s0;
		word_t   s1;
		word_t   t1;
		word_t   t2;
		digest_t h_out;
		for (int i = 0; i < 16; i++) w[i] = blk[i];
		for (int i = 16; i < 64; i++) begin
			s0 = ror(w[i-15], 7) ^ ror(w[i-15], 18) ^ (w[i-15] >> 3);
			s1 = ror(w[i-2], 17) ^ ror(w[i-2], 19) ^ (w[i-2] >> 10);
			w[i] = w[i-16] + s0 + w[i-7] + s1;
		end
		for (int j = 0; j < 8; j++) v[j] = h_in[j];
		for (int i = 0; i < 64; i++) begin
			t1 = v[7] + (ror(v[4], 6) ^ ror(v[4], 11) ^ ror(v[4], 25))
				+ ((v[4] & v[5]) ^ (~v[4] & v[6])) + ROUND_K[i] + w[i];
			t2 = (ror(v[0], 2) ^ ror(v[0], 13) ^ ror(v[0], 22))
				+ ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			for (int j = 7; j > 0; j--) v[j] = v[j-1];
			v[4] = v[4] + t1;        // e = d + t1
			v[0] = t1 + t2;
		end
		for (int j = 0; j < 8; j++) h_out[j] = h_in[j] + v[j];
		return h_out;
	endfunction

	// Double hash of the header with the nonce in its last field
	function automatic digest_t double_hash(input nonce_t n);
		logic [7:0] hdr [0:79];
		block_t     b0;
		block_t     b1;
		block_t     b2;
		digest_t    first;
		for (int i = 0; i < 80; i++) hdr[i] = HEADER[i];
		for (int i = 0; i < 4; i++) hdr[76 + i] = n[31 - 8 * i -: 8];
		for (int k = 0; k < 16; k++) begin
			b0[k] = {hdr[4*k+3], hdr[4*k+2], hdr[4*k+1], hdr[4*k]};   // Little endian fields
		end
		b1 = '0;
		for (int k = 0; k < 4; k++) begin
			b1[k] = {hdr[64+4*k+3], hdr[64+4*k+2], hdr[64+4*k+1], hdr[64+4*k]};
		end
		b1[4]  = 32'h8000_0000;
		b1[15] = 32'd640;            // 80 bytes in bits
		first  = compress(compress(HASH_INIT, b0), b1);
		b2 = '0;
		for (int k = 0; k < 8; k++) b2[k] = first[k];
		b2[8]  = 32'h8000_0000;
		b2[15] = 32'd256;
		return compress(HASH_INIT, b2);
	endfunction

	task automatic report(input string what, input logic [255:0] expected,
		input logic [255:0] actual);
		$display("Fail %s %s: expected %0h, actual %0h", label, what, expected, actual);
		error_count++;
	endtask

	//////////////////////////////
	// Per result and per test checks
	task check_result();
		digest_t model;
		logic    hit_exp;
		model   = double_hash(expected_nonce);
		hit_exp = (model[7] >> (32 - HIT_ZERO_BITS)) == 32'd0;
		result_count++;
		test_results++;
		if (result.digest !== model) report("digest", model, result.digest);
		if (result.nonce !== expected_nonce) report("nonce", 256'(expected_nonce), 256'(result.nonce));
		if (result.hit !== hit_exp) report("hit", 256'(hit_exp), 256'(result.hit));
		if (test_hits > 0) after_hit++;
		if (hit_exp) begin
			test_hits++;
			any_hit        = 1'b1;
			last_hit_nonce = expected_nonce;
		end
		expected_nonce[19:0] = expected_nonce[19:0] + 20'd1;   // No carry upward
	endtask

	task finish_test();
		if (running !== 1'b0) begin
			$display("%s: DUT still running at the end of the test", label);
			error_count++;
		end
		if (!test_long && test_results != 1) report("results", 256'(1), 256'(test_results));
		if (test_long && test_hits == 0) begin
			$display("%s: long scan ended without any hit", label);
			error_count++;
		end
		if (test_long && after_hit > 1) begin
			$display("Fail %s results after hit: expected at most 1, actual %0d", label, after_hit);
			error_count++;
		end
		if (op_count !== 48'(result_count)) report("op_count", 256'(result_count), 256'(op_count));
		if (found_valid !== any_hit) report("found_valid", 256'(any_hit), 256'(found_valid));
		if (any_hit && found_nonce !== last_hit_nonce) begin
			report("found_nonce", 256'(last_hit_nonce), 256'(found_nonce));
		end
		$display("%s: %0d results, %0d hits, %0d errors", label, test_results, test_hits,
			error_count - errors_at_start);
	endtask

	always @(posedge clk) begin
		if (reset) begin
			expected_nonce = NONCE_START;
			last_hit_nonce = '0;
			any_hit        = 1'b0;
			open_q         = 1'b0;
			error_count    = 0;
			result_count   = 0;
		end else begin
			if (test_open && !open_q) begin   // Test opens
				if (test_long) begin
					label = $sformatf("test%0d_long", test_num);
				end else begin
					label = $sformatf("test%0d_short", test_num);
				end
				test_results    = 0;
				test_hits       = 0;
				after_hit       = 0;
				errors_at_start = error_count;
			end
			if (result_valid) check_result();
			if (!test_open && open_q) finish_test();
			open_q = test_open;
		end
	end

endmodule

// ==== testbench/sha_miner_tb.sv ====
// SHA miner testbench top
`timescale 1ns/1ps
module sha_miner_tb import sha_miner_pkg::*; ();

	localparam int          TEST_COUNT = 12;
	localparam int unsigned HIT_BITS   = 4;        // About one hit per 16 nonces
	localparam logic [31:0] SEED       = 32'h112e_dfa8;

	logic           clk;
	logic           reset;
	logic           fire_button;
	logic           result_valid;
	digest_result_t result;
	logic           running;
	logic           found_valid;
	nonce_t         found_nonce;
	logic [47:0]    op_count;
	logic           test_open;      // High while one press and its results run
	logic           test_long;
	int             test_num;
	int             checked_errors;
	int             checked_results;
	int             timeouts;
	logic [31:0]    rand_state;

	sha_miner #(
		.PRESS_CYCLES  (4),
		.PULSE_CYCLES  (4),
		.LONG_CYCLES   (40),
		.RELEASE_CYCLES(8),
		.HIT_ZERO_BITS (HIT_BITS)
	) i_dut (
		.clk         (clk),
		.reset       (reset),
		.fire_button (fire_button),
		.result_valid(result_valid),
		.result      (result),
		.running     (running),
		.found_valid (found_valid),
		.found_nonce (found_nonce),
		.op_count    (op_count)
	);

	sha_miner_checker #(.HIT_ZERO_BITS(HIT_BITS)) i_checker (
		.clk         (clk),
		.reset       (reset),
		.result_valid(result_valid),
		.result      (result),
		.running     (running),
		.found_valid (found_valid),
		.found_nonce (found_nonce),
		.op_count    (op_count),
		.test_open   (test_open),
		.test_long   (test_long),
		.test_num    (test_num),
		.error_count (checked_errors),
		.result_count(checked_results)
	);

	always #4 clk = ~clk;   // 8 ns period

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Uniform pick in lo..hi from the upper LCG bits
	task automatic draw(input int lo, input int hi, output int value);
		int r;
		rand_state = lcg_step(rand_state);
		r = int'(rand_state >> 16);
		value = lo + r % (hi - lo + 1);
	endtask

	task automatic wait_running(input logic level, input int limit);
		int n;
		n = 0;
		while (running !== level && n < limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (running !== level) begin
			$display("Timeout: running did not reach %0d within %0d cycles", level, limit);
			timeouts++;
		end
	endtask

	//////////////////////////////
	// One press and its results
	task automatic press_test(input int num, input logic is_long);
		int hold;
		int gap;
		if (is_long) begin
			draw(60, 100, hold);        // Well past the long threshold
		end else begin
			draw(12, 30, hold);         // Short fire, never long
		end
		draw(5, 40, gap);
		test_num    = num;
		test_long   = is_long;
		test_open   = 1'b1;
		fire_button = 1'b1;
		repeat (hold) @(posedge clk);
		#1 fire_button = 1'b0;
		wait_running(1'b1, 200);
		if (timeouts == 0) begin
			wait_running(1'b0, 200_000);   // Long scans run until a hit
		end
		repeat (gap) @(posedge clk);
		#1 test_open = 1'b0;
		repeat (2) @(posedge clk);
		#1;
	endtask

	initial begin
		int pick;
		clk         = 1'b0;
		reset       = 1'b1;
		fire_button = 1'b0;
		test_open   = 1'b0;
		test_long   = 1'b0;
		test_num    = 0;
		timeouts    = 0;
		rand_state  = SEED;
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		for (int t = 1; t <= TEST_COUNT && timeouts == 0; t++) begin
			draw(0, 2, pick);
			press_test(t, (t == 2) || (pick == 0));   // Second test always long
		end
		repeat (4) @(posedge clk);
		#1;
		$display("Tests %0d, results %0d, errors %0d, timeouts %0d",
			test_num, checked_results, checked_errors, timeouts);
		if (checked_errors == 0 && timeouts == 0 && test_num == TEST_COUNT) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== sha_miner.f ====
hw/sha_miner_pkg.sv
hw/button_debounce.sv
hw/scan_control.sv
hw/nonce_tracker.sv
hw/sha256_block.sv
hw/sha_miner.sv
testbench/sha_miner_checker.sv
testbench/sha_miner_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SHA miner testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -j 0 --top-module sha_miner_tb -f sha_miner.f -o sha_miner_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sha_miner_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Result: PASSED" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
